/* source/cpu_macros.svh */
// Width and size definitions for the pipelined core.
// Included by the package and by every RTL file that sizes a port or a register.

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and register file
`define DATA_WIDTH       32
`define REG_ADDR_WIDTH   5
`define NUM_REGS         32

// Instruction and data addresses are byte addresses
`define INSTR_ADDR_WIDTH 16
`define PC_STEP          4

// Operand forwarding selects into execute
`define FWD_REG          2'd0
`define FWD_WB           2'd1
`define FWD_MEM          2'd2

`endif

/* source/cpuPkg.sv */
// Types shared across the pipeline: instruction encodings, the ALU operation set
// and the structs that carry an instruction from one stage to the next.
// Modules refer to these by scoped name.

`include "cpu_macros.svh"
`default_nettype none

package cpuPkg;

    // MIPS primary opcodes that the core implements
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opAddiu   = 6'd9,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcodeE;

    // Function field of R-type instructions
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42
    } functE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrc;
        aluOpE aluOp;
    } ctrlT;

    // Decode to execute
    typedef struct packed {
        ctrlT                             ctrl;
        logic [`REG_ADDR_WIDTH-1:0]       rsAddr;
        logic [`REG_ADDR_WIDTH-1:0]       rtAddr;
        logic [`REG_ADDR_WIDTH-1:0]       destAddr;
        logic [`DATA_WIDTH-1:0]           rsData;
        logic [`DATA_WIDTH-1:0]           rtData;
        logic [`DATA_WIDTH-1:0]           imm;
        logic [$clog2(`DATA_WIDTH)-1:0]   shamt;
    } decodedT;

    // Execute to memory
    typedef struct packed {
        ctrlT                       ctrl;
        logic [`REG_ADDR_WIDTH-1:0] destAddr;
        logic [`DATA_WIDTH-1:0]     result;
        logic [`DATA_WIDTH-1:0]     storeData;
    } execResultT;

endpackage

`default_nettype wire

/* source/fetchStage.sv */
// Fetch stage. Drives the program counter onto the instruction memory and
// registers the returned word into the decode slot.
// A load-use stall freezes both the counter and the fetched word.

`include "cpu_macros.svh"
`default_nettype none

module fetchStage (
    input  logic                         Clock,
    input  logic                         nReset,
    input  logic                         stall,
    input  logic [`DATA_WIDTH-1:0]       InstrMem,
    output logic [`INSTR_ADDR_WIDTH-1:0] InstrAddr,
    output logic [`DATA_WIDTH-1:0]       instruction
);

    localparam logic [`INSTR_ADDR_WIDTH-1:0] pcStep = `PC_STEP;

    // Instruction memory answers in the same cycle
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            InstrAddr   <= '0;
            instruction <= '0;
        end else if (!stall) begin
            InstrAddr   <= InstrAddr + pcStep;
            instruction <= InstrMem;
        end
    end

endmodule

`default_nettype wire

/* source/registerFile.sv */
// Thirty-two-entry register file with two read ports for decode and a
// debug read port for inspection from outside the core.
// Register 0 is hardwired to zero. A write in progress is visible to decode
// reads in the same cycle. The debug port shows stored contents only.

`include "cpu_macros.svh"
`default_nettype none

module registerFile (
    input  logic                       Clock,
    input  logic                       nReset,
    input  logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    input  logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    input  logic                       writeEnable,
    output logic [`DATA_WIDTH-1:0]     rsData,
    output logic [`DATA_WIDTH-1:0]     rtData,
    input  logic [`REG_ADDR_WIDTH-1:0] RegAddr,
    output logic [`DATA_WIDTH-1:0]     RegData
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
    logic                   writeValid;

    assign writeValid = writeEnable && (writeAddr != '0);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeValid) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through bypass
    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        if (writeValid && (addr == writeAddr)) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rsData  = readPort(rsAddr);
        rtData  = readPort(rtAddr);
        RegData = regs[RegAddr];
    end

    assert property (@(posedge Clock) disable iff (!nReset)
        (rsAddr != '0 || rsData == '0) && (rtAddr != '0 || rtData == '0));

endmodule

`default_nettype wire

/* source/decodeStage.sv */
// Decode stage. Splits the instruction word, looks up control, extends the
// immediate and picks the destination, then registers everything with the
// register operands into the execute slot.
// Source addresses an instruction does not read are reported as register 0.

`include "cpu_macros.svh"
`default_nettype none

module decodeStage (
    input  logic                       Clock,
    input  logic                       nReset,
    input  logic [`DATA_WIDTH-1:0]     instruction,
    input  logic                       stall,
    input  logic [`DATA_WIDTH-1:0]     rsData,
    input  logic [`DATA_WIDTH-1:0]     rtData,
    output logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    output logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    output cpuPkg::decodedT            decoded
);

    cpuPkg::opcodeE             opcode;
    cpuPkg::functE              funct;
    cpuPkg::ctrlT               ctrl;
    cpuPkg::ctrlT               ctrlIssued;
    logic                       usesRs;
    logic                       usesRt;
    logic                       signExtend;
    logic [`REG_ADDR_WIDTH-1:0] destAddr;
    logic [`DATA_WIDTH-1:0]     imm;

    assign opcode = cpuPkg::opcodeE'(instruction[31:26]);
    assign funct  = cpuPkg::functE'(instruction[5:0]);

    // ------------------------------------------------------------
    // Control lookup
    // ------------------------------------------------------------
    always_comb begin
        ctrl       = '0;
        usesRs     = 1'b0;
        usesRt     = 1'b0;
        signExtend = 1'b1;
        case (opcode)
            cpuPkg::opSpecial: begin
                ctrl.regWrite = 1'b1;
                usesRs        = 1'b1;
                usesRt        = 1'b1;
                case (funct)
                    cpuPkg::fnSll: begin
                        ctrl.aluOp = cpuPkg::aluSll;
                        usesRs     = 1'b0;
                    end
                    cpuPkg::fnSrl: begin
                        ctrl.aluOp = cpuPkg::aluSrl;
                        usesRs     = 1'b0;
                    end
                    cpuPkg::fnAddu: ctrl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: ctrl.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd:  ctrl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:   ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnXor:  ctrl.aluOp = cpuPkg::aluXor;
                    cpuPkg::fnSlt:  ctrl.aluOp = cpuPkg::aluSlt;
                    default: begin
                        // Unknown function behaves as a nop
                        ctrl.regWrite = 1'b0;
                        usesRs        = 1'b0;
                        usesRt        = 1'b0;
                    end
                endcase
            end
            cpuPkg::opAddiu: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                usesRs        = 1'b1;
            end
            cpuPkg::opAndi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = cpuPkg::aluAnd;
                usesRs        = 1'b1;
                signExtend    = 1'b0;
            end
            cpuPkg::opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = cpuPkg::aluOr;
                usesRs        = 1'b1;
                signExtend    = 1'b0;
            end
            cpuPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                usesRs        = 1'b1;
            end
            cpuPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                usesRs        = 1'b1;
                usesRt        = 1'b1;
            end
            default: ;
        endcase
    end

    assign rsAddr   = usesRs ? instruction[25:21] : '0;
    assign rtAddr   = usesRt ? instruction[20:16] : '0;
    assign destAddr = (opcode == cpuPkg::opSpecial) ? instruction[15:11] : instruction[20:16];

    assign imm = signExtend ? {{(`DATA_WIDTH-16){instruction[15]}}, instruction[15:0]}
                            : {{(`DATA_WIDTH-16){1'b0}}, instruction[15:0]};

    // Bubble while the load ahead completes
    assign ctrlIssued = stall ? '0 : ctrl;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            decoded <= '0;
        end else begin
            decoded <= '{ctrl:     ctrlIssued,
                         rsAddr:   rsAddr,
                         rtAddr:   rtAddr,
                         destAddr: destAddr,
                         rsData:   rsData,
                         rtData:   rtData,
                         imm:      imm,
                         shamt:    instruction[10:6]};
        end
    end

endmodule

`default_nettype wire

/* source/executeStage.sv */
// Execute stage. Resolves both operands through the forwarding muxes, runs
// the ALU and registers the outcome into the memory slot.
// The forwarded rt value travels on as store data.

`include "cpu_macros.svh"
`default_nettype none

module executeStage (
    input  logic                   Clock,
    input  logic                   nReset,
    input  cpuPkg::decodedT        decoded,
    input  logic [1:0]             forwardA,
    input  logic [1:0]             forwardB,
    input  cpuPkg::execResultT     memoryResult,
    input  logic [`DATA_WIDTH-1:0] writeData,
    output cpuPkg::execResultT     result
);

    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] rtValue;
    logic [`DATA_WIDTH-1:0] aluOut;

    function automatic logic [`DATA_WIDTH-1:0] forwardMux(
        input logic [1:0]             sel,
        input logic [`DATA_WIDTH-1:0] regValue
    );
        case (sel)
            `FWD_MEM: return memoryResult.result;
            `FWD_WB:  return writeData;
            default:  return regValue;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Operands and ALU
    // ------------------------------------------------------------
    always_comb begin
        operandA = forwardMux(forwardA, decoded.rsData);
        rtValue  = forwardMux(forwardB, decoded.rtData);
        operandB = decoded.ctrl.aluSrc ? decoded.imm : rtValue;
        case (decoded.ctrl.aluOp)
            cpuPkg::aluAdd: aluOut = operandA + operandB;
            cpuPkg::aluSub: aluOut = operandA - operandB;
            cpuPkg::aluAnd: aluOut = operandA & operandB;
            cpuPkg::aluOr:  aluOut = operandA | operandB;
            cpuPkg::aluXor: aluOut = operandA ^ operandB;
            cpuPkg::aluSlt: aluOut = {{(`DATA_WIDTH-1){1'b0}},
                                      $signed(operandA) < $signed(operandB)};
            // Shift amount from the instruction, value from rt
            cpuPkg::aluSll: aluOut = operandB << decoded.shamt;
            cpuPkg::aluSrl: aluOut = operandB >> decoded.shamt;
            default:        aluOut = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            result <= '0;
        end else begin
            result <= '{ctrl:      decoded.ctrl,
                        destAddr:  decoded.destAddr,
                        result:    aluOut,
                        storeData: rtValue};
        end
    end

    assert property (@(posedge Clock) disable iff (!nReset)
        !(decoded.ctrl.memRead && decoded.ctrl.memWrite));

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
// Hazard unit. Chooses the forwarding source for each execute operand and
// raises stall when decode needs the result of a load still in execute.
// Purely combinational.

`include "cpu_macros.svh"
`default_nettype none

module hazardUnit (
    input  logic [`REG_ADDR_WIDTH-1:0] decodeRsAddr,
    input  logic [`REG_ADDR_WIDTH-1:0] decodeRtAddr,
    input  cpuPkg::decodedT            execute,
    input  cpuPkg::execResultT         memory,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic                       writeEnable,
    output logic [1:0]                 forwardA,
    output logic [1:0]                 forwardB,
    output logic                       stall
);

    logic loadInExecute;

    // Memory stage wins over writeback since it is younger
    function automatic logic [1:0] forwardSel(input logic [`REG_ADDR_WIDTH-1:0] src);
        if (memory.ctrl.regWrite && !memory.ctrl.memRead
                && (memory.destAddr != '0) && (memory.destAddr == src)) begin
            return `FWD_MEM;
        end
        if (writeEnable && (writeAddr != '0) && (writeAddr == src)) begin
            return `FWD_WB;
        end
        return `FWD_REG;
    endfunction

    always_comb begin
        forwardA = forwardSel(execute.rsAddr);
        forwardB = forwardSel(execute.rtAddr);
    end

    // Load data is not ready until writeback
    assign loadInExecute = execute.ctrl.memRead && (execute.destAddr != '0);
    assign stall = loadInExecute && ((execute.destAddr == decodeRsAddr)
                                  || (execute.destAddr == decodeRtAddr));

endmodule

`default_nettype wire

/* source/processor.sv */
// Top level of the five-stage core. Wires fetch, decode, execute and the
// hazard unit together, drives the data memory from the memory slot and
// holds the writeback register.
// Memory is accessed in fixed pipeline slots. Load data arrives on MemData
// one cycle after MemRead. nStall is low during a load-use bubble.

`include "cpu_macros.svh"
`default_nettype none

module processor (
    input  logic                         Clock,
    input  logic                         nReset,
    input  logic [`DATA_WIDTH-1:0]       MemData,
    input  logic [`DATA_WIDTH-1:0]       InstrMem,
    input  logic [`REG_ADDR_WIDTH-1:0]   RegAddr,
    output logic [`INSTR_ADDR_WIDTH-1:0] InstrAddr,
    output logic [`INSTR_ADDR_WIDTH-1:0] MemAddr,
    output logic [`DATA_WIDTH-1:0]       WriteData,
    output logic                         MemRead,
    output logic                         MemWrite,
    output logic                         nStall,
    output logic [`DATA_WIDTH-1:0]       RegData
);

    logic                       stall;
    logic [`DATA_WIDTH-1:0]     instruction;
    logic [`REG_ADDR_WIDTH-1:0] rsAddr;
    logic [`REG_ADDR_WIDTH-1:0] rtAddr;
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rtData;
    cpuPkg::decodedT            decoded;
    cpuPkg::execResultT         memoryResult;
    logic [1:0]                 forwardA;
    logic [1:0]                 forwardB;

    cpuPkg::ctrlT               wbCtrl;
    logic [`REG_ADDR_WIDTH-1:0] wbDest;
    logic [`DATA_WIDTH-1:0]     wbResult;
    logic [`DATA_WIDTH-1:0]     writeData;
    logic                       writeEnable;

    fetchStage i_fetchStage (
        .Clock       (Clock),
        .nReset      (nReset),
        .stall       (stall),
        .InstrMem    (InstrMem),
        .InstrAddr   (InstrAddr),
        .instruction (instruction)
    );

    decodeStage i_decodeStage (
        .Clock       (Clock),
        .nReset      (nReset),
        .instruction (instruction),
        .stall       (stall),
        .rsData      (rsData),
        .rtData      (rtData),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .decoded     (decoded)
    );

    registerFile i_registerFile (
        .Clock       (Clock),
        .nReset      (nReset),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .writeAddr   (wbDest),
        .writeData   (writeData),
        .writeEnable (writeEnable),
        .rsData      (rsData),
        .rtData      (rtData),
        .RegAddr     (RegAddr),
        .RegData     (RegData)
    );

    executeStage i_executeStage (
        .Clock        (Clock),
        .nReset       (nReset),
        .decoded      (decoded),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .memoryResult (memoryResult),
        .writeData    (writeData),
        .result       (memoryResult)
    );

    hazardUnit i_hazardUnit (
        .decodeRsAddr (rsAddr),
        .decodeRtAddr (rtAddr),
        .execute      (decoded),
        .memory       (memoryResult),
        .writeAddr    (wbDest),
        .writeEnable  (writeEnable),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .stall        (stall)
    );

    // ------------------------------------------------------------
    // Memory slot
    // ------------------------------------------------------------
    assign MemAddr   = memoryResult.result[`INSTR_ADDR_WIDTH-1:0];
    assign WriteData = memoryResult.storeData;
    assign MemRead   = memoryResult.ctrl.memRead;
    assign MemWrite  = memoryResult.ctrl.memWrite;
    assign nStall    = !stall;

    // ------------------------------------------------------------
    // Writeback slot
    // ------------------------------------------------------------
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            wbCtrl <= '0;
        end else begin
            wbCtrl <= memoryResult.ctrl;
        end
    end

    always_ff @(posedge Clock) begin
        wbDest   <= memoryResult.destAddr;
        wbResult <= memoryResult.result;
    end

    // Load data comes straight from the bus this cycle
    assign writeData   = wbCtrl.memToReg ? MemData : wbResult;
    assign writeEnable = wbCtrl.regWrite;

    // One bubble clears the load out of execute
    assert property (@(posedge Clock) disable iff (!nReset) !nStall |=> nStall);

endmodule

`default_nettype wire

/* tb/processorTb.sv */
// Testbench for the pipelined core. Builds a random program from a fixed seed,
// runs it on the DUT next to an instruction-set model and compares registers,
// the store sequence, the final data memory, stall cycles and fetch progress.
// Instruction memory answers combinationally, load data arrives one cycle late.

`include "cpu_macros.svh"
`default_nettype none

module processorTb;

    localparam int progLen    = 60;
    localparam int dataWords  = 64;
    localparam int imemWords  = 256;
    localparam int runTimeout = 1000;
    localparam logic [`INSTR_ADDR_WIDTH-1:0] endAddr = (progLen + 8) * 4;

    // MIPS encodings
    localparam logic [5:0] opSpecial = 6'd0;
    localparam logic [5:0] opAddiu   = 6'd9;
    localparam logic [5:0] opAndi    = 6'd12;
    localparam logic [5:0] opOri     = 6'd13;
    localparam logic [5:0] opLw      = 6'd35;
    localparam logic [5:0] opSw      = 6'd43;
    localparam logic [5:0] functs [8] = '{6'd0, 6'd2, 6'd33, 6'd35, 6'd36, 6'd37, 6'd38, 6'd42};

    logic                         Clock;
    logic                         nReset;
    logic [`DATA_WIDTH-1:0]       MemData;
    logic [`DATA_WIDTH-1:0]       InstrMem;
    logic [`REG_ADDR_WIDTH-1:0]   RegAddr;
    logic [`INSTR_ADDR_WIDTH-1:0] InstrAddr;
    logic [`INSTR_ADDR_WIDTH-1:0] MemAddr;
    logic [`DATA_WIDTH-1:0]       WriteData;
    logic                         MemRead;
    logic                         MemWrite;
    logic                         nStall;
    logic [`DATA_WIDTH-1:0]       RegData;

    logic [31:0] imem [imemWords];
    logic [31:0] dmem [dataWords];
    logic [31:0] modelMem [dataWords];
    logic [31:0] modelRegs [`NUM_REGS];
    logic [15:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    int          loadUsePairs;
    int          errors;
    int          stallCycles;
    int          storeCount;
    logic        monitoring;
    logic        haveLast;
    logic        lastStall;
    logic [15:0] lastAddr;
    logic        readPending;
    logic [5:0]  readIndex;

    processor i_processor (
        .Clock     (Clock),
        .nReset    (nReset),
        .MemData   (MemData),
        .InstrMem  (InstrMem),
        .RegAddr   (RegAddr),
        .InstrAddr (InstrAddr),
        .MemAddr   (MemAddr),
        .WriteData (WriteData),
        .MemRead   (MemRead),
        .MemWrite  (MemWrite),
        .nStall    (nStall),
        .RegData   (RegData)
    );

    always #20 Clock = ~Clock;

    assign InstrMem = imem[InstrAddr[9:2]];

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic finishRun();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // Registers 0 to 7 only, so dependencies are dense
    function automatic logic [31:0] randomInstr();
        int         kind;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sh;
        logic [5:0] fn;
        kind = $urandom_range(13, 0);
        rs   = $urandom_range(7, 0);
        rt   = $urandom_range(7, 0);
        rd   = $urandom_range(7, 0);
        if (kind < 8) begin
            fn = functs[kind];
            sh = (kind < 2) ? 5'($urandom_range(31, 0)) : 5'd0;
            return {opSpecial, rs, rt, rd, sh, fn};
        end
        case (kind)
            8:       return {opAddiu, rs, rt, 16'($urandom())};
            9:       return {opAndi, rs, rt, 16'($urandom())};
            10:      return {opOri, rs, rt, 16'($urandom())};
            13:      return {opSw, 5'd0, rt, 16'($urandom_range(dataWords - 1, 0) * 4)};
            default: return {opLw, 5'd0, rt, 16'($urandom_range(dataWords - 1, 0) * 4)};
        endcase
    endfunction

    // Source registers an instruction reads
    function automatic logic readsReg(input logic [31:0] instr, input logic [4:0] r);
        logic [5:0] op;
        op = instr[31:26];
        if (op == opSpecial && (instr[5:0] == 6'd0 || instr[5:0] == 6'd2)) begin
            return instr[20:16] == r;
        end
        if (op == opSpecial || op == opSw) begin
            return instr[25:21] == r || instr[20:16] == r;
        end
        return instr[25:21] == r;
    endfunction

    task automatic runModel();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immS;
        logic [31:0] immZ;
        logic [15:0] ea;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] value;
        logic        writes;
        loadUsePairs = 0;
        for (int i = 0; i < progLen; i++) begin
            instr  = imem[i];
            a      = modelRegs[instr[25:21]];
            rt     = instr[20:16];
            b      = modelRegs[rt];
            immS   = {{16{instr[15]}}, instr[15:0]};
            immZ   = {16'd0, instr[15:0]};
            ea     = 16'(a + immS);
            dest   = rt;
            writes = 1'b1;
            value  = '0;
            case (instr[31:26])
                opSpecial: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        6'd0:  value = b << instr[10:6];
                        6'd2:  value = b >> instr[10:6];
                        6'd33: value = a + b;
                        6'd35: value = a - b;
                        6'd36: value = a & b;
                        6'd37: value = a | b;
                        6'd38: value = a ^ b;
                        default: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                opAddiu: value = a + immS;
                opAndi:  value = a & immZ;
                opOri:   value = a | immZ;
                opLw:    value = modelMem[ea[7:2]];
                default: begin
                    writes = 1'b0;
                    modelMem[ea[7:2]] = b;
                    storeAddrQ.push_back(ea);
                    storeDataQ.push_back(b);
                end
            endcase
            if (writes && dest != 0) begin
                modelRegs[dest] = value;
            end
            if (instr[31:26] == opLw && rt != 0 && readsReg(imem[i + 1], rt)) begin
                loadUsePairs++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Data memory and per-cycle checks
    // ------------------------------------------------------------
    always @(negedge Clock) begin
        if (monitoring) begin
            if (haveLast) begin
                checkValue("InstrAddr", InstrAddr, lastStall ? lastAddr : lastAddr + 16'd4);
            end
            haveLast  = 1'b1;
            lastAddr  = InstrAddr;
            lastStall = !nStall;
            if (!nStall) begin
                stallCycles++;
            end
            if (MemRead) begin
                readPending = 1'b1;
                readIndex   = MemAddr[7:2];
            end
            if (MemWrite) begin
                if (storeCount < storeAddrQ.size()) begin
                    checkValue("MemAddr", MemAddr, storeAddrQ[storeCount]);
                    checkValue("WriteData", WriteData, storeDataQ[storeCount]);
                end else begin
                    errors++;
                    $display("Error at %0t: store to %h beyond the expected stores", $time, MemAddr);
                end
                storeCount++;
                dmem[MemAddr[7:2]] = WriteData;
            end
        end
    end

    // Load data shows up in the writeback slot
    always @(posedge Clock) begin
        #2;
        if (readPending) begin
            MemData     = dmem[readIndex];
            readPending = 1'b0;
        end
    end

    initial begin
        int cycles;
        Clock        = 1'b0;
        nReset       = 1'b0;
        MemData      = '0;
        RegAddr      = '0;
        errors       = 0;
        stallCycles  = 0;
        storeCount   = 0;
        monitoring   = 1'b0;
        haveLast     = 1'b0;
        lastStall    = 1'b0;
        lastAddr     = '0;
        readPending  = 1'b0;
        readIndex    = '0;
        void'($urandom(33));
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = (i < progLen) ? randomInstr() : 32'd0;
        end
        for (int i = 0; i < dataWords; i++) begin
            dmem[i]     = $urandom();
            modelMem[i] = dmem[i];
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        runModel();

        repeat (2) @(posedge Clock);
        #2;
        nReset     = 1'b1;
        monitoring = 1'b1;
        @(negedge Clock);
        checkValue("InstrAddr", InstrAddr, 32'd0);
        checkValue("MemRead", MemRead, 1'b0);
        checkValue("MemWrite", MemWrite, 1'b0);
        checkValue("nStall", nStall, 1'b1);

        cycles = 0;
        while (InstrAddr <= endAddr && cycles < runTimeout) begin
            @(negedge Clock);
            cycles++;
        end
        if (InstrAddr <= endAddr) begin
            errors++;
            $display("Timeout: the program counter never passed the end of the program");
        end else begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                @(posedge Clock);
                #2;
                RegAddr = r;
                @(negedge Clock);
                checkValue($sformatf("RegData[%0d]", r), RegData, modelRegs[r]);
            end
            for (int i = 0; i < dataWords; i++) begin
                checkValue($sformatf("data memory word %0d", i), dmem[i], modelMem[i]);
            end
            checkValue("store count", storeCount, storeAddrQ.size());
            checkValue("stall cycles", stallCycles, loadUsePairs);
        end
        finishRun();
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/cpuPkg.sv
source/fetchStage.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/hazardUnit.sv
source/processor.sv
tb/processorTb.sv

/* Bender.yml */
package:
  name: processor

sources:
  - include_dirs:
      - source
    files:
      - source/cpuPkg.sv
      - source/fetchStage.sv
      - source/registerFile.sv
      - source/decodeStage.sv
      - source/executeStage.sv
      - source/hazardUnit.sv
      - source/processor.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/processorTb.sv
